/* logic/rvCfg.svh */
// Core configuration macros
`ifndef RvCfgSvh
`define RvCfgSvh

// data and address width
`define RvXlen 32

// first fetch address after reset
`define RvResetPc 32'h0000_0000

// architectural register count, x0 included
`define RvRegCount 32

`endif

/* logic/rvPkg.sv */
// Core types package
`include "rvCfg.svh"

package rvPkg;

  // register index width
  localparam int regIdW = $clog2(`RvRegCount);

  // alu operations, the compare ops return 1 in bit 0 when true
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSltu,
    aluPassB,
    aluEq,
    aluNe,
    aluLt,
    aluGe
  } aluOpE;

  // IF/ID contents
  typedef struct packed {
    logic              valid;
    logic [`RvXlen-1:0] pc;
    logic [`RvXlen-1:0] inst;
  } fetchBundle;

  typedef struct packed {
    logic [regIdW-1:0]  rd;
    logic [regIdW-1:0]  rs1;
    logic [regIdW-1:0]  rs2;
    logic [`RvXlen-1:0] imm;
    aluOpE              aluOp;
    logic               useImm;
    logic               usePcA;
    logic               regWen;
    logic               isBranch;
    logic               isJal;
    logic               isJalr;
    logic               isEbreak;
    logic               illegal;
  } decodedOp;

  typedef struct packed {
    logic               wen;
    logic [regIdW-1:0]  rd;
    logic [`RvXlen-1:0] data;
  } regWrite;

  // one entry of the retire trace
  typedef struct packed {
    logic [`RvXlen-1:0] pc;
    logic [regIdW-1:0]  rd;
    logic               wen;
    logic [`RvXlen-1:0] wdata;
    logic               halt;
  } retireRec;

endpackage

/* logic/fetchUnit.sv */
// Instruction fetch stage
`timescale 1ns/1ps
`include "rvCfg.svh"

module fetchUnit (
  input  logic               clk,
  input  logic               rstN,
  input  logic               redirect,
  input  logic [`RvXlen-1:0] redirectPc,
  input  logic               halted,
  output logic [`RvXlen-1:0] imemAddr,
  input  logic [`RvXlen-1:0] imemData,
  output rvPkg::fetchBundle  fetched
);

  logic [`RvXlen-1:0] pcQ;
  logic               ifIdValid;
  logic [`RvXlen-1:0] ifIdPc;
  logic [`RvXlen-1:0] ifIdInst;

  // halt freezes the pc, a redirect beats the sequential step
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcQ <= `RvResetPc;
    end else if (!halted) begin
      pcQ <= redirect ? redirectPc : pcQ + `RvXlen'd4;
    end
  end

  // wrong-path slot becomes a bubble on redirect
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifIdValid <= 1'b0;
    end else begin
      ifIdValid <= !redirect && !halted;
    end
  end

  always_ff @(posedge clk) begin
    ifIdPc   <= pcQ;
    ifIdInst <= imemData;
  end

  assign imemAddr = pcQ;
  assign fetched  = '{valid: ifIdValid, pc: ifIdPc, inst: ifIdInst};

  redirectAligned: assert property (
    @(posedge clk) disable iff (!rstN) redirect |-> redirectPc[1:0] == 2'b00
  ) else $error("redirect target %h not word aligned", redirectPc);

endmodule

/* logic/instDecoder.sv */
// RV32I subset decoder
`timescale 1ns/1ps
`include "rvCfg.svh"

module instDecoder (
  input  logic [`RvXlen-1:0] inst,
  output rvPkg::decodedOp    op
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [`RvXlen-1:0] immI;
  logic [`RvXlen-1:0] immU;
  logic [`RvXlen-1:0] immB;
  logic [`RvXlen-1:0] immJ;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // sign-extended immediates
  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immU = {inst[31:12], 12'b0};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op     = '0;
    op.rd  = inst[11:7];
    op.rs1 = inst[19:15];
    op.rs2 = inst[24:20];
    op.aluOp = rvPkg::aluAdd;
    case (opcode)
      7'b0110011: begin
        op.regWen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: op.aluOp = rvPkg::aluAdd;
          10'b0100000_000: op.aluOp = rvPkg::aluSub;
          10'b0000000_010: op.aluOp = rvPkg::aluSlt;
          10'b0000000_011: op.aluOp = rvPkg::aluSltu;
          10'b0000000_100: op.aluOp = rvPkg::aluXor;
          10'b0000000_110: op.aluOp = rvPkg::aluOr;
          10'b0000000_111: op.aluOp = rvPkg::aluAnd;
          default:         op.illegal = 1'b1;
        endcase
      end
      7'b0010011: begin
        op.regWen = 1'b1;
        op.useImm = 1'b1;
        op.imm    = immI;
        case (funct3)
          3'b000:  op.aluOp = rvPkg::aluAdd;
          3'b010:  op.aluOp = rvPkg::aluSlt;
          3'b100:  op.aluOp = rvPkg::aluXor;
          3'b110:  op.aluOp = rvPkg::aluOr;
          3'b111:  op.aluOp = rvPkg::aluAnd;
          // shifts and sltiu are outside the subset
          default: op.illegal = 1'b1;
        endcase
      end
      7'b0110111: begin
        op.regWen = 1'b1;
        op.useImm = 1'b1;
        op.imm    = immU;
        op.aluOp  = rvPkg::aluPassB;
      end
      7'b0010111: begin
        op.regWen = 1'b1;
        op.useImm = 1'b1;
        op.usePcA = 1'b1;
        op.imm    = immU;
      end
      7'b1100011: begin
        op.isBranch = 1'b1;
        op.imm      = immB;
        case (funct3)
          3'b000:  op.aluOp = rvPkg::aluEq;
          3'b001:  op.aluOp = rvPkg::aluNe;
          3'b100:  op.aluOp = rvPkg::aluLt;
          3'b101:  op.aluOp = rvPkg::aluGe;
          default: op.illegal = 1'b1;
        endcase
      end
      7'b1101111: begin
        op.regWen = 1'b1;
        op.isJal  = 1'b1;
        op.imm    = immJ;
      end
      7'b1100111: begin
        // target is rs1 + imm from the alu sum
        op.regWen  = 1'b1;
        op.isJalr  = 1'b1;
        op.useImm  = 1'b1;
        op.imm     = immI;
        op.illegal = funct3 != 3'b000;
      end
      7'b1110011: begin
        op.isEbreak = inst == 32'h0010_0073;
        op.illegal  = inst != 32'h0010_0073;
      end
      default: op.illegal = 1'b1;
    endcase
  end

endmodule

/* logic/regFile.sv */
// Integer register file
`timescale 1ns/1ps
`include "rvCfg.svh"

module regFile (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [rvPkg::regIdW-1:0] rs1,
  input  logic [rvPkg::regIdW-1:0] rs2,
  output logic [`RvXlen-1:0]       rdata1,
  output logic [`RvXlen-1:0]       rdata2,
  input  rvPkg::regWrite           wr
);

  // x0 has no storage
  logic [`RvXlen-1:0] regs [1:`RvRegCount-1];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < `RvRegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.wen && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // same-cycle write is forwarded to the reader
  assign rdata1 = (rs1 == '0) ? '0 :
                  (wr.wen && wr.rd == rs1) ? wr.data : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 :
                  (wr.wen && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

/* logic/executeUnit.sv */
// Execute stage with ALU and branch resolution
`timescale 1ns/1ps
`include "rvCfg.svh"

module executeUnit (
  input  rvPkg::fetchBundle  fetched,
  input  rvPkg::decodedOp    op,
  input  logic [`RvXlen-1:0] rdata1,
  input  logic [`RvXlen-1:0] rdata2,
  output logic               resultValid,
  output rvPkg::retireRec    result,
  output logic               redirect,
  output logic [`RvXlen-1:0] redirectPc
);

  logic [`RvXlen-1:0] opA;
  logic [`RvXlen-1:0] opB;
  logic [`RvXlen-1:0] aluRes;
  logic [`RvXlen-1:0] branchTarget;
  logic [`RvXlen-1:0] linkAddr;
  logic               taken;

  assign opA = op.usePcA ? fetched.pc : rdata1;
  assign opB = op.useImm ? op.imm : rdata2;

  always_comb begin
    aluRes = '0;
    case (op.aluOp)
      rvPkg::aluAdd:   aluRes = opA + opB;
      rvPkg::aluSub:   aluRes = opA - opB;
      rvPkg::aluAnd:   aluRes = opA & opB;
      rvPkg::aluOr:    aluRes = opA | opB;
      rvPkg::aluXor:   aluRes = opA ^ opB;
      rvPkg::aluSlt:   aluRes[0] = $signed(opA) < $signed(opB);
      rvPkg::aluSltu:  aluRes[0] = opA < opB;
      rvPkg::aluPassB: aluRes = opB;
      rvPkg::aluEq:    aluRes[0] = opA == opB;
      rvPkg::aluNe:    aluRes[0] = opA != opB;
      rvPkg::aluLt:    aluRes[0] = $signed(opA) < $signed(opB);
      rvPkg::aluGe:    aluRes[0] = $signed(opA) >= $signed(opB);
      default:         aluRes = '0;
    endcase
  end

  // jal and taken branches share the pc-relative target
  assign branchTarget = fetched.pc + op.imm;
  assign linkAddr     = fetched.pc + `RvXlen'd4;
  assign taken        = op.isBranch && aluRes[0];

  assign redirect   = fetched.valid && (taken || op.isJal || op.isJalr);
  assign redirectPc = op.isJalr ? {aluRes[`RvXlen-1:1], 1'b0} : branchTarget;

  assign resultValid  = fetched.valid;
  assign result.pc    = fetched.pc;
  assign result.rd    = op.rd;
  assign result.wen   = op.regWen && !op.illegal;
  assign result.wdata = (op.isJal || op.isJalr) ? linkAddr : aluRes;
  // ebreak and any unknown encoding stop the core
  assign result.halt  = op.isEbreak || op.illegal;

endmodule

/* logic/retireUnit.sv */
// Retire stage and halt latch
`timescale 1ns/1ps

module retireUnit (
  input  logic            clk,
  input  logic            rstN,
  input  logic            resultValid,
  input  rvPkg::retireRec result,
  output logic            retireValid,
  output rvPkg::retireRec retire,
  output rvPkg::regWrite  wr,
  output logic            halted
);

  logic            exWbValid;
  rvPkg::retireRec exWb;
  logic            haltQ;
  logic            haltNow;

  assign haltNow = exWbValid && exWb.halt;
  assign halted  = haltQ || haltNow;

  // nothing younger than a halt record gets in
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exWbValid <= 1'b0;
      haltQ     <= 1'b0;
    end else begin
      exWbValid <= resultValid && !halted;
      haltQ     <= halted;
    end
  end

  always_ff @(posedge clk) begin
    if (resultValid && !halted) begin
      exWb <= result;
    end
  end

  assign retireValid = exWbValid;
  assign retire      = exWb;
  assign wr          = '{wen: exWbValid && exWb.wen, rd: exWb.rd, data: exWb.wdata};

  haltNoWrite: assert property (
    @(posedge clk) disable iff (!rstN) retireValid && retire.halt |-> !wr.wen
  ) else $error("halt record requests a register write");

endmodule

/* logic/rvCore.sv */
// Three-stage RV32I subset core
`timescale 1ns/1ps
`include "rvCfg.svh"

module rvCore (
  input  logic               clk,
  input  logic               rstN,
  output logic [`RvXlen-1:0] imemAddr,
  input  logic [`RvXlen-1:0] imemData,
  output logic               retireValid,
  output rvPkg::retireRec    retire,
  output logic               halted
);

  rvPkg::fetchBundle        fetched;
  rvPkg::decodedOp          op;
  rvPkg::retireRec          result;
  rvPkg::regWrite           wr;
  logic [`RvXlen-1:0]       rdata1;
  logic [`RvXlen-1:0]       rdata2;
  logic [`RvXlen-1:0]       redirectPc;
  logic                     redirect;
  logic                     resultValid;

  fetchUnit uFetch (
    .clk        (clk),
    .rstN       (rstN),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .halted     (halted),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .fetched    (fetched)
  );

  instDecoder uDecoder (
    .inst (fetched.inst),
    .op   (op)
  );

  // read in execute, written from retire
  regFile uRegFile (
    .clk    (clk),
    .rstN   (rstN),
    .rs1    (op.rs1),
    .rs2    (op.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wr     (wr)
  );

  executeUnit uExecute (
    .fetched     (fetched),
    .op          (op),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .resultValid (resultValid),
    .result      (result),
    .redirect    (redirect),
    .redirectPc  (redirectPc)
  );

  retireUnit uRetire (
    .clk         (clk),
    .rstN        (rstN),
    .resultValid (resultValid),
    .result      (result),
    .retireValid (retireValid),
    .retire      (retire),
    .wr          (wr),
    .halted      (halted)
  );

endmodule

/* tb/instRom.sv */
// Test program ROM
`timescale 1ns/1ps

module instRom (
  input  logic [31:0] addr,
  output logic [31:0] data
);

  logic [31:0] mem [0:63];

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  initial begin
    // opcode 0 is illegal, so a stray fetch past the program halts
    for (int i = 0; i < 64; i++) begin
      mem[i] = {i[24:0], 7'b0000000};
    end
    mem[0]  = iType(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);
    mem[1]  = iType(-12'sd3, 5'd0, 3'b000, 5'd2, 7'b0010011);
    // dependent pairs on x3 and x1
    mem[2]  = rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    mem[3]  = rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
    mem[4]  = rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
    mem[5]  = rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
    mem[6]  = rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);
    mem[7]  = rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);
    mem[8]  = rType(7'h00, 5'd1, 5'd2, 3'b011, 5'd9);
    mem[9]  = iType(12'h00f, 5'd2, 3'b111, 5'd10, 7'b0010011);
    mem[10] = iType(12'h100, 5'd1, 3'b110, 5'd11, 7'b0010011);
    mem[11] = iType(12'hfff, 5'd1, 3'b100, 5'd12, 7'b0010011);
    mem[12] = iType(12'd1, 5'd2, 3'b010, 5'd13, 7'b0010011);
    mem[13] = {20'h12345, 5'd14, 7'b0110111};
    mem[14] = {20'h00001, 5'd15, 7'b0010111};
    // write to x0, then read it back
    mem[15] = iType(12'd7, 5'd1, 3'b000, 5'd0, 7'b0010011);
    mem[16] = rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd16);
    mem[17] = bType(13'd8, 5'd1, 5'd1, 3'b000);
    mem[18] = iType(12'd99, 5'd0, 3'b000, 5'd17, 7'b0010011);
    mem[19] = bType(13'd8, 5'd2, 5'd1, 3'b000);
    mem[20] = bType(13'd8, 5'd2, 5'd1, 3'b001);
    mem[21] = iType(12'd98, 5'd0, 3'b000, 5'd17, 7'b0010011);
    mem[22] = bType(13'd8, 5'd1, 5'd1, 3'b001);
    mem[23] = bType(13'd8, 5'd1, 5'd2, 3'b100);
    mem[24] = iType(12'd97, 5'd0, 3'b000, 5'd17, 7'b0010011);
    mem[25] = bType(13'd8, 5'd2, 5'd1, 3'b100);
    mem[26] = bType(13'd8, 5'd2, 5'd1, 3'b101);
    mem[27] = iType(12'd96, 5'd0, 3'b000, 5'd17, 7'b0010011);
    mem[28] = bType(13'd8, 5'd1, 5'd2, 3'b101);
    mem[29] = jType(21'd8, 5'd18);
    mem[30] = iType(12'd95, 5'd0, 3'b000, 5'd17, 7'b0010011);
    mem[31] = iType(12'h084, 5'd0, 3'b000, 5'd19, 7'b0010011);
    mem[32] = iType(12'd4, 5'd19, 3'b000, 5'd20, 7'b1100111);
    mem[33] = iType(12'd94, 5'd0, 3'b000, 5'd17, 7'b0010011);
    mem[34] = rType(7'h00, 5'd18, 5'd20, 3'b000, 5'd21);
    mem[35] = 32'h0010_0073;
  end

  assign data = mem[addr[7:2]];

endmodule

/* tb/rvCoreTb.sv */
// Core testbench with reference model
`timescale 1ns/1ps
`include "rvCfg.svh"

module rvCoreTb;

  localparam int progLen    = 36;
  localparam int cycleLimit = 4 * progLen + 20;
  // six wrong-path slots are squashed
  localparam int expRetires = 30;

  logic                clk;
  logic                rstN;
  logic [`RvXlen-1:0]  imemAddr;
  logic [`RvXlen-1:0]  imemData;
  logic                retireValid;
  rvPkg::retireRec     retire;
  logic                halted;

  // reference model state
  logic [31:0]         mPc;
  logic [31:0]         mRegs [0:31];
  logic [31:0]         mInst;
  logic [31:0]         mA;
  logic [31:0]         mB;
  logic [31:0]         immI;
  logic [31:0]         immU;
  logic [31:0]         immB;
  logic [31:0]         immJ;
  logic                brTake;
  rvPkg::retireRec     expRec;
  logic [31:0]         expNext;
  logic                expTaken;
  logic                expJump;
  logic                prevTaken;
  logic [31:0]         prevPc;

  int                  cycles;
  int                  sinceRst;
  int                  retireCount;
  logic                seenRetire;
  int                  fails [0:5];
  int                  testsFailed;
  int                  otherFails;

  rvCore DUT (
    .clk         (clk),
    .rstN        (rstN),
    .imemAddr    (imemAddr),
    .imemData    (imemData),
    .retireValid (retireValid),
    .retire      (retire),
    .halted      (halted)
  );

  instRom uRom (
    .addr (imemAddr),
    .data (imemData)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // architectural step from the ISA rules
  always_comb begin
    mInst    = uRom.mem[mPc[7:2]];
    mA       = mRegs[mInst[19:15]];
    mB       = mRegs[mInst[24:20]];
    immI     = {{20{mInst[31]}}, mInst[31:20]};
    immU     = {mInst[31:12], 12'b0};
    immB     = {{19{mInst[31]}}, mInst[31], mInst[7], mInst[30:25], mInst[11:8], 1'b0};
    immJ     = {{11{mInst[31]}}, mInst[31], mInst[19:12], mInst[20], mInst[30:21], 1'b0};
    expRec   = '0;
    expRec.pc = mPc;
    expRec.rd = mInst[11:7];
    expNext  = mPc + 32'd4;
    expTaken = 1'b0;
    expJump  = 1'b0;
    brTake   = 1'b0;
    case (mInst[6:0])
      7'h33: begin
        expRec.wen = 1'b1;
        case ({mInst[31:25], mInst[14:12]})
          10'h000: expRec.wdata = mA + mB;
          10'h100: expRec.wdata = mA - mB;
          10'h007: expRec.wdata = mA & mB;
          10'h006: expRec.wdata = mA | mB;
          10'h004: expRec.wdata = mA ^ mB;
          10'h002: expRec.wdata = {31'b0, $signed(mA) < $signed(mB)};
          10'h003: expRec.wdata = {31'b0, mA < mB};
          default: begin
            expRec.wen  = 1'b0;
            expRec.halt = 1'b1;
          end
        endcase
      end
      7'h13: begin
        expRec.wen = 1'b1;
        case (mInst[14:12])
          3'd0: expRec.wdata = mA + immI;
          3'd2: expRec.wdata = {31'b0, $signed(mA) < $signed(immI)};
          3'd4: expRec.wdata = mA ^ immI;
          3'd6: expRec.wdata = mA | immI;
          3'd7: expRec.wdata = mA & immI;
          default: begin
            expRec.wen  = 1'b0;
            expRec.halt = 1'b1;
          end
        endcase
      end
      7'h37: begin
        expRec.wen   = 1'b1;
        expRec.wdata = immU;
      end
      7'h17: begin
        expRec.wen   = 1'b1;
        expRec.wdata = mPc + immU;
      end
      7'h63: begin
        case (mInst[14:12])
          3'd0: brTake = mA == mB;
          3'd1: brTake = mA != mB;
          3'd4: brTake = $signed(mA) < $signed(mB);
          3'd5: brTake = $signed(mA) >= $signed(mB);
          default: expRec.halt = 1'b1;
        endcase
        if (brTake) begin
          expNext  = mPc + immB;
          expTaken = 1'b1;
        end
      end
      7'h6f: begin
        expRec.wen   = 1'b1;
        expRec.wdata = mPc + 32'd4;
        expNext      = mPc + immJ;
        expTaken     = 1'b1;
        expJump      = 1'b1;
      end
      7'h67: begin
        expRec.wen   = 1'b1;
        expRec.wdata = mPc + 32'd4;
        expNext      = (mA + immI) & ~32'd1;
        expTaken     = 1'b1;
        expJump      = 1'b1;
      end
      // ebreak and everything unknown
      default: expRec.halt = 1'b1;
    endcase
  end

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mPc         <= `RvResetPc;
      prevTaken   <= 1'b0;
      prevPc      <= '0;
      retireCount <= 0;
      for (int i = 0; i < 32; i++) begin
        mRegs[i] <= '0;
      end
    end else if (retireValid) begin
      if (expRec.wen && expRec.rd != 5'd0) begin
        mRegs[expRec.rd] <= expRec.wdata;
      end
      mPc         <= expNext;
      prevTaken   <= expTaken;
      prevPc      <= mPc;
      retireCount <= retireCount + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rstN) begin
      sinceRst   <= 0;
      seenRetire <= 1'b0;
    end else begin
      sinceRst <= sinceRst + 1;
      if (retireValid) begin
        seenRetire <= 1'b1;
      end
    end
  end

  task automatic noteFail(input int idx);
    fails[idx] = fails[idx] + 1;
  endtask

  task automatic report(input int idx, input string name);
    if (fails[idx] == 0) begin
      $display("ok      %s", name);
    end else begin
      $display("failed  %s (%0d errors)", name, fails[idx]);
      testsFailed = testsFailed + 1;
    end
  endtask

  aResetQuiet: assert property (@(posedge clk)
    !rstN || $rose(rstN) |-> !retireValid && !halted && imemAddr == `RvResetPc)
    else begin
      noteFail(0);
      $display("outputs not quiet during or right after reset");
    end

  aFirstRetire: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && !seenRetire |-> sinceRst == 2 && retire.pc == `RvResetPc)
    else begin
      noteFail(0);
      $display("Fail first retire latency got %h expected %h", $sampled(sinceRst), 2);
    end

  aPc: assert property (@(posedge clk) disable iff (!rstN)
    retireValid |-> retire.pc == expRec.pc)
    else begin
      noteFail(1);
      $display("Fail retire.pc got %h expected %h", $sampled(retire.pc), $sampled(expRec.pc));
    end

  aWen: assert property (@(posedge clk) disable iff (!rstN)
    retireValid |-> retire.wen == expRec.wen)
    else begin
      noteFail(1);
      $display("Fail retire.wen got %h expected %h", $sampled(retire.wen),
               $sampled(expRec.wen));
    end

  aRd: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && expRec.wen |-> retire.rd == expRec.rd)
    else begin
      noteFail(1);
      $display("Fail retire.rd got %h expected %h", $sampled(retire.rd), $sampled(expRec.rd));
    end

  aWdata: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && expRec.wen |-> retire.wdata == expRec.wdata)
    else begin
      noteFail(2);
      $display("Fail retire.wdata got %h expected %h", $sampled(retire.wdata),
               $sampled(expRec.wdata));
    end

  // the wrong-path slot after a redirect must not show up
  aSquash: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && prevTaken |-> retire.pc != prevPc + 32'd4)
    else begin
      noteFail(3);
      $display("Fail retire.pc got %h after redirect from %h", $sampled(retire.pc),
               $sampled(prevPc));
    end

  aLink: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && expJump |-> retire.wdata == expRec.pc + 32'd4)
    else begin
      noteFail(3);
      $display("Fail link retire.wdata got %h expected %h", $sampled(retire.wdata),
               $sampled(expRec.pc) + 32'd4);
    end

  // x0 writes keep their record, reads of x0 give zero
  aX0: assert property (@(posedge clk) disable iff (!rstN)
    retireValid && expRec.wen &&
    (expRec.rd == 5'd0 ||
     (mInst[6:0] == 7'h33 || mInst[6:0] == 7'h13) && mInst[19:15] == 5'd0)
    |-> retire.rd == expRec.rd && retire.wdata == expRec.wdata)
    else begin
      noteFail(4);
      $display("Fail x0 retire.wdata got %h expected %h", $sampled(retire.wdata),
               $sampled(expRec.wdata));
    end

  aHaltFlag: assert property (@(posedge clk) disable iff (!rstN)
    retireValid |-> retire.halt == expRec.halt && (!retire.halt || halted))
    else begin
      noteFail(5);
      $display("Fail retire.halt got %h expected %h", $sampled(retire.halt),
               $sampled(expRec.halt));
    end

  aStayHalted: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> halted && !retireValid)
    else begin
      noteFail(5);
      $display("core left halt or retired after halting");
    end

  initial begin
    rstN        = 1'b0;
    cycles      = 0;
    testsFailed = 0;
    otherFails  = 0;
    for (int i = 0; i < 6; i++) begin
      fails[i] = 0;
    end
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    while (!seenRetire && cycles < cycleLimit) @(posedge clk);
    @(posedge clk);
    report(0, "reset and first retire latency");
    while (!halted && cycles < cycleLimit) @(posedge clk);
    @(posedge clk);
    report(1, "retire records against the model");
    report(2, "write-back values and dependent pairs");
    report(3, "branches and jumps");
    report(4, "writes to x0");
    // keep running to the limit to watch for stray retires
    while (cycles < cycleLimit) @(posedge clk);
    report(5, "halt on ebreak");
    if (!halted) begin
      $display("timeout: the core never halted");
      otherFails = otherFails + 1;
    end
    if (retireCount != expRetires) begin
      $display("retired %0d instructions instead of %0d", retireCount, expRetires);
      otherFails = otherFails + 1;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d run errors", 6, 6 - testsFailed,
             testsFailed, otherFails);
    if (testsFailed == 0 && otherFails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
logic/rvPkg.sv
logic/fetchUnit.sv
logic/instDecoder.sv
logic/regFile.sv
logic/executeUnit.sv
logic/retireUnit.sv
logic/rvCore.sv
tb/instRom.sv
tb/rvCoreTb.sv

/* Makefile */
TOP := rvCoreTb

.PHONY: default lint clean

default:
	verilator --binary --assert --top-module $(TOP) -f flist.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
